/* design/fmSynthPkg.sv */
`default_nettype none

package fmSynthPkg;

	typedef logic [19:0] phaseT;
	typedef logic [31:0] ctrlT;
	typedef logic signed [7:0] pcmT;
	typedef logic [11:0] accumT;
	typedef logic [3:0] chanT;
	typedef logic [31:0] busDataT;

	localparam int numChannels = 16;

	// register selectors from address bits 3:2
	localparam logic [1:0] regCtrlA = 2'd0;
	localparam logic [1:0] regPhaseA = 2'd1;
	localparam logic [1:0] regCtrlB = 2'd2;
	localparam logic [1:0] regPhaseB = 2'd3;

	localparam int opmRead = 3;
	localparam int opmWrite = 4;
	localparam logic [1:0] busOkReady = 2'b00;

	// one full period with its peak at index 16
	localparam pcmT sineTable [64] = '{
		8'h00, 8'h0C, 8'h18, 8'h24, 8'h30, 8'h3B, 8'h46, 8'h50,
		8'h59, 8'h62, 8'h69, 8'h70, 8'h75, 8'h79, 8'h7C, 8'h7E,
		8'h7F, 8'h7E, 8'h7C, 8'h79, 8'h75, 8'h70, 8'h69, 8'h62,
		8'h59, 8'h50, 8'h46, 8'h3B, 8'h30, 8'h24, 8'h18, 8'h0C,
		8'h00, 8'hF4, 8'hE8, 8'hDC, 8'hD0, 8'hC5, 8'hBA, 8'hB0,
		8'hA7, 8'h9E, 8'h97, 8'h90, 8'h8B, 8'h87, 8'h84, 8'h82,
		8'h81, 8'h82, 8'h84, 8'h87, 8'h8B, 8'h90, 8'h97, 8'h9E,
		8'hA7, 8'hB0, 8'hBA, 8'hC5, 8'hD0, 8'hDC, 8'hE8, 8'hF4
	};

	// halfSel is phase bit 18 for the gated modes
	function automatic pcmT shapeWave(input logic [3:0] wave, input logic [5:0] index,
		input logic [5:0] indexDouble, input logic halfSel);
		pcmT base;
		pcmT fast;
		pcmT shaped;
		base = sineTable[index];
		fast = sineTable[indexDouble];
		case (wave)
			4'h1: shaped = base[7] ? 8'h00 : base;
			4'h2: shaped = base[7] ? ~base : base;
			4'h3: shaped = halfSel ? 8'h00 : base;
			4'h4: shaped = halfSel ? 8'h00 : fast;
			4'h5: shaped = halfSel ? 8'h00 : (fast[7] ? ~fast : fast);
			4'h6: shaped = base[7] ? 8'h80 : 8'h7F;
			4'h7: shaped = pcmT'({~index[5], index[4:0], index[4:3]});
			default: shaped = base;
		endcase
		return shaped;
	endfunction

	// shifts here are logical on the raw byte
	function automatic pcmT attenuate(input pcmT value, input logic [2:0] atten,
		input logic [2:0] shift);
		logic [7:0] raw;
		logic [7:0] level;
		raw = value;
		level = raw;
		if (atten[0])
			level = level - (raw >> 3);
		if (atten[1])
			level = level - (raw >> 2);
		if (atten[2])
			level = level - (raw >> 1);
		return pcmT'(level >> shift);
	endfunction

endpackage

`default_nettype wire

/* design/fmRateTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module fmRateTimer #(
	parameter logic [15:0] StepIncrement = 16'h4000
)(
	input wire logic clock,
	input wire logic rstN,
	output logic stepStrobe
);

	logic [15:0] fraction;
	logic [15:0] nextFraction;
	logic carry;

	// carry out of the fraction marks one channel slot
	assign {carry, nextFraction} = {1'b0, fraction} + {1'b0, StepIncrement};

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			fraction <= '0;
			stepStrobe <= 1'b0;
		end
		else
		begin
			fraction <= nextFraction;
			stepStrobe <= carry;
		end
	end

endmodule

`default_nettype wire

/* design/fmChannelSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fmChannelSequencer
	import fmSynthPkg::*;
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic stepStrobe,
	output logic slotStrobe,
	output chanT slotChannel,
	output logic voiceValid,
	output chanT voiceChannel,
	output logic frameEnd
);

	chanT rover;
	logic lastSlot;
	logic [2:0] lastPipe;

	assign lastSlot = slotStrobe && (slotChannel == chanT'(numChannels - 1));

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			rover <= '0;
			slotStrobe <= 1'b0;
			slotChannel <= '0;
			voiceValid <= 1'b0;
			voiceChannel <= '0;
			lastPipe <= '0;
			frameEnd <= 1'b0;
		end
		else
		begin
			slotStrobe <= stepStrobe;
			if (stepStrobe)
			begin
				slotChannel <= rover;
				rover <= rover + 1'b1;
			end
			// voice reads the phase one cycle after its update
			voiceValid <= slotStrobe;
			voiceChannel <= slotChannel;
			// follow the last channel through the voice, then close the frame
			lastPipe <= {lastPipe[1:0], lastSlot};
			frameEnd <= lastPipe[2];
		end
	end

endmodule

`default_nettype wire

/* design/fmRegFile.sv */
`timescale 1ns/1ps
`default_nettype none

module fmRegFile
	import fmSynthPkg::*;
#(
	parameter logic [11:0] DeviceBase = 12'h008
)(
	input wire logic clock,
	input wire logic rstN,
	input wire busDataT busAddr,
	input wire busDataT busWriteData,
	input wire logic [4:0] busOpm,
	output busDataT busReadData,
	output logic [1:0] busOk,
	input wire logic slotStrobe,
	input wire chanT slotChannel,
	input wire chanT voiceChannel,
	output ctrlT ctrlA,
	output ctrlT ctrlB,
	output phaseT phaseA,
	output phaseT phaseB
);

	ctrlT ctrlARegs [numChannels];
	ctrlT ctrlBRegs [numChannels];
	phaseT phaseARegs [numChannels];
	phaseT phaseBRegs [numChannels];

	logic devSel;
	logic busRead;
	logic busWrite;
	chanT busChannel;
	logic [1:0] regSel;
	busDataT readMux;

	assign devSel = (busAddr[27:16] == DeviceBase);
	assign busChannel = busAddr[8:5];
	assign regSel = busAddr[3:2];
	assign busRead = devSel && busOpm[opmRead];
	assign busWrite = devSel && busOpm[opmWrite];

	// voice side read port
	assign ctrlA = ctrlARegs[voiceChannel];
	assign ctrlB = ctrlBRegs[voiceChannel];
	assign phaseA = phaseARegs[voiceChannel];
	assign phaseB = phaseBRegs[voiceChannel];

	always_comb
	begin
		case (regSel)
			regCtrlA: readMux = ctrlARegs[busChannel];
			regPhaseA: readMux = busDataT'(phaseARegs[busChannel]);
			regCtrlB: readMux = ctrlBRegs[busChannel];
			default: readMux = busDataT'(phaseBRegs[busChannel]);
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < numChannels; i++)
			begin
				ctrlARegs[i] <= '0;
				ctrlBRegs[i] <= '0;
				phaseARegs[i] <= '0;
				phaseBRegs[i] <= '0;
			end
			busReadData <= '0;
			busOk <= busOkReady;
		end
		else
		begin
			busReadData <= busRead ? readMux : '0;
			busOk <= busOkReady;
			// once per frame per channel
			if (slotStrobe)
			begin
				phaseARegs[slotChannel] <= phaseARegs[slotChannel] + ctrlARegs[slotChannel][19:0];
				phaseBRegs[slotChannel] <= phaseBRegs[slotChannel] + ctrlBRegs[slotChannel][19:0];
			end
			// bus write lands last, so it wins over the update
			if (busWrite)
			begin
				case (regSel)
					regCtrlA: ctrlARegs[busChannel] <= busWriteData;
					regPhaseA: phaseARegs[busChannel] <= busWriteData[19:0];
					regCtrlB: ctrlBRegs[busChannel] <= busWriteData;
					default: phaseBRegs[busChannel] <= busWriteData[19:0];
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/fmVoice.sv */
`timescale 1ns/1ps
`default_nettype none

module fmVoice
	import fmSynthPkg::*;
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic voiceValid,
	input wire ctrlT ctrlA,
	input wire ctrlT ctrlB,
	input wire phaseT phaseA,
	input wire phaseT phaseB,
	output pcmT sample,
	output logic sampleValid
);

	pcmT shapedB;
	pcmT sampleB;
	ctrlT ctrlAHeld;
	phaseT phaseAHeld;
	logic stageBValid;
	logic [5:0] modOffset;
	logic [5:0] indexA;
	logic [5:0] indexADouble;
	pcmT shapedA;
	pcmT mixedA;

	// wave in 31:28, shift in 27:25, atten in 24:22 and modulate in bit 21
	assign shapedB = attenuate(shapeWave(ctrlB[31:28], phaseB[19:14], phaseB[18:13], phaseB[18]),
		ctrlB[24:22], ctrlB[27:25]);

	// B bends the index of A when modulating
	assign modOffset = ctrlAHeld[21] ? sampleB[7:2] : 6'd0;
	assign indexA = phaseAHeld[19:14] + modOffset;
	assign indexADouble = phaseAHeld[18:13] + modOffset;
	assign shapedA = attenuate(shapeWave(ctrlAHeld[31:28], indexA, indexADouble, phaseAHeld[18]),
		ctrlAHeld[24:22], ctrlAHeld[27:25]);
	assign mixedA = ctrlAHeld[21] ? shapedA : shapedA + sampleB;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			stageBValid <= 1'b0;
			sampleValid <= 1'b0;
		end
		else
		begin
			stageBValid <= voiceValid;
			sampleValid <= stageBValid;
		end
	end

	// A operands ride along with B so two channels can overlap
	always_ff @(posedge clock)
	begin
		if (voiceValid)
		begin
			sampleB <= shapedB;
			ctrlAHeld <= ctrlA;
			phaseAHeld <= phaseA;
		end
		if (stageBValid)
			sample <= mixedA;
	end

endmodule

`default_nettype wire

/* design/fmMixer.sv */
`timescale 1ns/1ps
`default_nettype none

module fmMixer
	import fmSynthPkg::*;
(
	input wire logic clock,
	input wire logic rstN,
	input wire pcmT sample,
	input wire logic sampleValid,
	input wire logic frameEnd,
	output pcmT pcmLeft,
	output pcmT pcmRight,
	output logic pcmStrobe
);

	accumT accum;
	accumT sampleWide;
	pcmT saturated;
	pcmT pcmHeld;

	assign sampleWide = {{4{sample[7]}}, sample};

	// clip when the top nibble is not a sign copy
	always_comb
	begin
		if (accum[11:8] != {4{accum[7]}})
			saturated = accum[11] ? 8'h80 : 8'h7F;
		else
			saturated = pcmT'(accum[7:0]);
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			accum <= '0;
			pcmHeld <= '0;
			pcmStrobe <= 1'b0;
		end
		else
		begin
			pcmStrobe <= frameEnd;
			if (frameEnd)
			begin
				pcmHeld <= saturated;
				// a sample landing on the boundary opens the next frame
				accum <= sampleValid ? sampleWide : '0;
			end
			else if (sampleValid)
				accum <= accum + sampleWide;
		end
	end

	// mono mix on both sides
	assign pcmLeft = pcmHeld;
	assign pcmRight = pcmHeld;

endmodule

`default_nettype wire

/* design/fmSynthTop.sv */
`timescale 1ns/1ps
`default_nettype none

module fmSynthTop
	import fmSynthPkg::*;
#(
	parameter logic [15:0] StepIncrement = 16'h4000,
	parameter logic [11:0] DeviceBase = 12'h008
)(
	input wire logic clock,
	input wire logic rstN,
	input wire busDataT busAddr,
	input wire busDataT busWriteData,
	input wire logic [4:0] busOpm,
	output busDataT busReadData,
	output logic [1:0] busOk,
	output pcmT pcmLeft,
	output pcmT pcmRight,
	output logic pcmStrobe
);

	logic stepStrobe;
	logic slotStrobe;
	chanT slotChannel;
	logic voiceValid;
	chanT voiceChannel;
	logic frameEnd;
	ctrlT ctrlA;
	ctrlT ctrlB;
	phaseT phaseA;
	phaseT phaseB;
	pcmT sample;
	logic sampleValid;

	fmRateTimer #(
		.StepIncrement(StepIncrement)
	) u_rateTimer (
		.clock(clock),
		.rstN(rstN),
		.stepStrobe(stepStrobe)
	);

	fmChannelSequencer u_sequencer (
		.clock(clock),
		.rstN(rstN),
		.stepStrobe(stepStrobe),
		.slotStrobe(slotStrobe),
		.slotChannel(slotChannel),
		.voiceValid(voiceValid),
		.voiceChannel(voiceChannel),
		.frameEnd(frameEnd)
	);

	fmRegFile #(
		.DeviceBase(DeviceBase)
	) u_regFile (
		.clock(clock),
		.rstN(rstN),
		.busAddr(busAddr),
		.busWriteData(busWriteData),
		.busOpm(busOpm),
		.busReadData(busReadData),
		.busOk(busOk),
		.slotStrobe(slotStrobe),
		.slotChannel(slotChannel),
		.voiceChannel(voiceChannel),
		.ctrlA(ctrlA),
		.ctrlB(ctrlB),
		.phaseA(phaseA),
		.phaseB(phaseB)
	);

	fmVoice u_voice (
		.clock(clock),
		.rstN(rstN),
		.voiceValid(voiceValid),
		.ctrlA(ctrlA),
		.ctrlB(ctrlB),
		.phaseA(phaseA),
		.phaseB(phaseB),
		.sample(sample),
		.sampleValid(sampleValid)
	);

	fmMixer u_mixer (
		.clock(clock),
		.rstN(rstN),
		.sample(sample),
		.sampleValid(sampleValid),
		.frameEnd(frameEnd),
		.pcmLeft(pcmLeft),
		.pcmRight(pcmRight),
		.pcmStrobe(pcmStrobe)
	);

endmodule

`default_nettype wire

/* verification/fmClockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module fmClockGen #(
	parameter realtime HalfPeriod = 20ns,
	parameter int ResetCycles = 3
)(
	output logic clock,
	output logic rstN
);

	initial
	begin
		clock = 1'b0;
		forever #(HalfPeriod) clock = ~clock;
	end

	initial
	begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clock);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

/* verification/fmSynthModel.svh */
`ifndef FM_SYNTH_MODEL_SVH
`define FM_SYNTH_MODEL_SVH

// register mirror of the DUT
logic [31:0] ctrlAModel [16];
logic [31:0] ctrlBModel [16];
logic [19:0] phaseAModel [16];
logic [19:0] phaseBModel [16];

// quarter wave mirrored and negated for the rest of the period
function automatic logic [7:0] sineAt(input logic [5:0] idx);
	logic [7:0] quarter [17];
	logic [7:0] mag;
	quarter = '{8'h00, 8'h0C, 8'h18, 8'h24, 8'h30, 8'h3B, 8'h46, 8'h50, 8'h59,
		8'h62, 8'h69, 8'h70, 8'h75, 8'h79, 8'h7C, 8'h7E, 8'h7F};
	mag = (idx[4:0] <= 16) ? quarter[idx[4:0]] : quarter[32 - idx[4:0]];
	return idx[5] ? 8'h00 - mag : mag;
endfunction

function automatic logic [7:0] shapeSample(input logic [3:0] wave, input logic [5:0] idx,
	input logic [5:0] idxDouble, input logic half);
	logic [7:0] s;
	logic [7:0] d;
	s = sineAt(idx);
	d = sineAt(idxDouble);
	case (wave)
		1: return s[7] ? 8'h00 : s;
		2: return s[7] ? ~s : s;
		3: return half ? 8'h00 : s;
		4: return half ? 8'h00 : d;
		5: return half ? 8'h00 : (d[7] ? ~d : d);
		6: return s[7] ? 8'h80 : 8'h7F;
		7: return ({idx, 2'b00} | {6'd0, idx[4:3]}) ^ 8'h80;
		default: return s;
	endcase
endfunction

function automatic logic [7:0] attenuateSample(input logic [7:0] v, input logic [2:0] a,
	input logic [2:0] sh);
	logic [7:0] r;
	r = v;
	if (a[0])
		r = r - (v >> 3);
	if (a[1])
		r = r - (v >> 2);
	if (a[2])
		r = r - (v >> 1);
	return r >> sh;
endfunction

function automatic logic [7:0] voiceSample(input logic [31:0] cA, input logic [31:0] cB,
	input logic [19:0] pA, input logic [19:0] pB);
	logic [7:0] b;
	logic [7:0] a;
	logic [5:0] offset;
	b = attenuateSample(shapeSample(cB[31:28], pB[19:14], pB[18:13], pB[18]),
		cB[24:22], cB[27:25]);
	offset = cA[21] ? b[7:2] : 6'd0;
	a = attenuateSample(shapeSample(cA[31:28], pA[19:14] + offset, pA[18:13] + offset, pA[18]),
		cA[24:22], cA[27:25]);
	return cA[21] ? a : a + b;
endfunction

// sum of all channels clipped to 8 bits
function automatic logic [7:0] frameMix();
	logic [11:0] sum;
	logic [7:0] v;
	sum = '0;
	for (int c = 0; c < 16; c++)
	begin
		v = voiceSample(ctrlAModel[c], ctrlBModel[c], phaseAModel[c], phaseBModel[c]);
		sum = sum + {{4{v[7]}}, v};
	end
	if (sum[11:8] != {4{sum[7]}})
		return sum[11] ? 8'h80 : 8'h7F;
	return sum[7:0];
endfunction

task automatic writeRaw(input logic [31:0] addr, input logic [31:0] data);
	@(posedge clock);
	busAddr <= addr;
	busWriteData <= data;
	busOpm <= 5'b1 << opmWrite;
	@(posedge clock);
	busOpm <= '0;
endtask

task automatic writeReg(input int chan, input logic [1:0] sel, input logic [31:0] data);
	writeRaw({4'h0, deviceBase, 7'h0, chan[3:0], 1'b0, sel, 2'b00}, data);
	case (sel)
		regCtrlA: ctrlAModel[chan] = data;
		regPhaseA: phaseAModel[chan] = data[19:0];
		regCtrlB: ctrlBModel[chan] = data;
		default: phaseBModel[chan] = data[19:0];
	endcase
endtask

// callers return on a rising edge, so the read goes out at once
task automatic readReg(input int chan, input logic [1:0] sel, output logic [31:0] data);
	busAddr <= {4'h0, deviceBase, 7'h0, chan[3:0], 1'b0, sel, 2'b00};
	busOpm <= 5'b1 << opmRead;
	@(posedge clock);
	busOpm <= '0;
	@(posedge clock);
	data = busReadData;
endtask

`endif

/* verification/fmSynthTb.sv */
`timescale 1ns/1ps
`default_nettype none

module fmSynthTb
	import fmSynthPkg::*;
;

	localparam logic [11:0] deviceBase = 12'h008;
	// 16 slots of four cycles
	localparam int frameCycles = 64;
	// frame budgets of readback, select, static, saturation, phase, modulation and margin
	localparam int timeoutCycles = (4 + 2 + 8 + 12 + 10 + 12 + 8) * frameCycles;

	logic clock;
	logic rstN;
	busDataT busAddr;
	busDataT busWriteData;
	logic [4:0] busOpm;
	busDataT busReadData;
	logic [1:0] busOk;
	pcmT pcmLeft;
	pcmT pcmRight;
	logic pcmStrobe;
	integer seed = 88768;
	int cycles = 0;
	int lastPulse = -1;

	`include "fmSynthModel.svh"

	fmClockGen u_clockGen (.clock(clock), .rstN(rstN));

	fmSynthTop #(
		.StepIncrement(16'h4000),
		.DeviceBase(deviceBase)
	) u_dut (
		.clock(clock),
		.rstN(rstN),
		.busAddr(busAddr),
		.busWriteData(busWriteData),
		.busOpm(busOpm),
		.busReadData(busReadData),
		.busOk(busOk),
		.pcmLeft(pcmLeft),
		.pcmRight(pcmRight),
		.pcmStrobe(pcmStrobe)
	);

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic waitPulses(input int count);
		repeat (count)
		begin
			do
				@(posedge clock);
			while (!pcmStrobe);
		end
	endtask

	task automatic checkOutputs(input string name);
		waitPulses(3);
		checkValue({name, " left"}, frameMix(), pcmLeft);
		checkValue({name, " right"}, frameMix(), pcmRight);
	endtask

	// one single-cycle strobe per frame
	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (pcmStrobe)
		begin
			if (lastPulse >= 0)
				checkValue("strobe period", frameCycles, cycles - lastPulse);
			lastPulse <= cycles;
		end
		if (cycles >= timeoutCycles)
		begin
			$display("Timeout after %0d cycles without finishing the tests", cycles);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		logic [31:0] data;
		logic [31:0] expected;
		logic [31:0] word;
		logic [19:0] freq;
		logic [19:0] preset;
		int chan;
		int sel;
		int count;
		busAddr = '0;
		busWriteData = '0;
		busOpm = '0;
		for (int c = 0; c < 16; c++)
		begin
			ctrlAModel[c] = '0;
			ctrlBModel[c] = '0;
			phaseAModel[c] = '0;
			phaseBModel[c] = '0;
		end
		wait (rstN === 1'b1);

		// register readback
		repeat (24)
		begin
			chan = {$random(seed)} % 16;
			sel = {$random(seed)} % 4;
			word = $random(seed);
			writeReg(chan, sel[1:0], word);
			readReg(chan, sel[1:0], data);
			expected = sel[0] ? {12'h000, word[19:0]} : word;
			checkValue("readback", expected, data);
			checkValue("busOk", busOkReady, busOk);
		end

		// a write to another device base must not hit
		chan = {$random(seed)} % 16;
		writeRaw({4'h0, deviceBase + 12'h001, 7'h0, chan[3:0], 1'b0, regCtrlB, 2'b00},
			$random(seed));
		readReg(chan, regCtrlB, data);
		checkValue("device select", ctrlBModel[chan], data);

		// static tone
		for (int c = 0; c < 16; c++)
		begin
			word = $random(seed);
			writeReg(c, regCtrlA, {word[31:21], 21'd0});
			word = $random(seed);
			writeReg(c, regCtrlB, {word[31:21], 21'd0});
			writeReg(c, regPhaseA, $random(seed));
			writeReg(c, regPhaseB, $random(seed));
		end
		checkOutputs("static tone");

		// saturation with square waves
		for (int c = 0; c < 16; c++)
		begin
			writeReg(c, regCtrlA, 32'h6000_0000);
			writeReg(c, regCtrlB, 32'h0);
			writeReg(c, regPhaseA, 32'h4_0000);
			writeReg(c, regPhaseB, 32'h0);
		end
		waitPulses(3);
		checkValue("saturation high", 32'h7F, {24'h0, pcmLeft});
		for (int c = 0; c < 16; c++)
			writeReg(c, regPhaseA, 32'hC_0000);
		waitPulses(3);
		checkValue("saturation low", 32'h80, {24'h0, pcmLeft});
		checkValue("saturation low right", 32'h80, {24'h0, pcmRight});

		// phase advance on channel 15
		freq = $random(seed);
		preset = $random(seed);
		count = 3 + {$random(seed)} % 3;
		writeReg(15, regCtrlA, {12'h000, freq});
		waitPulses(1);
		writeReg(15, regPhaseA, {12'h000, preset});
		waitPulses(count);
		readReg(15, regPhaseA, data);
		expected = {12'h000, 20'(preset + count * freq)};
		checkValue("phase advance", expected, data);

		// modulation against plain sum on one channel
		for (int c = 0; c < 16; c++)
		begin
			writeReg(c, regCtrlA, 32'h0);
			writeReg(c, regCtrlB, 32'h0);
			writeReg(c, regPhaseA, 32'h0);
			writeReg(c, regPhaseB, 32'h0);
		end
		chan = {$random(seed)} % 16;
		word = $random(seed);
		writeReg(chan, regCtrlB, {word[31:21], 21'd0});
		writeReg(chan, regPhaseA, $random(seed));
		writeReg(chan, regPhaseB, $random(seed));
		word = $random(seed);
		writeReg(chan, regCtrlA, {word[31:22], 1'b1, 21'd0});
		checkOutputs("modulate");
		writeReg(chan, regCtrlA, {word[31:22], 1'b0, 21'd0});
		checkOutputs("sum");

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verification
design/fmSynthPkg.sv
design/fmRateTimer.sv
design/fmChannelSequencer.sv
design/fmRegFile.sv
design/fmVoice.sv
design/fmMixer.sv
design/fmSynthTop.sv
verification/fmClockGen.sv
verification/fmSynthTb.sv

/* run.sh */
#!/bin/sh
# build and run the FM synth testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wall -Wno-fatal \
	-f filelist.f \
	--top-module fmSynthTb \
	-Mdir obj_dir
./obj_dir/VfmSynthTb
